//--- Bender.yml
package:
  name: execute_stage

sources:
  - src/exec_pkg.sv
  - src/exec_bus_if.sv
  - src/operand_forward.sv
  - src/alu_shifter.sv
  - src/branch_resolve.sv
  - src/ex_mem_reg.sv
  - src/execute_stage.sv
  - target: simulation
    files:
      - bench/execute_stage_checker.sv
      - bench/execute_stage_tb.sv

//--- bench/execute_cases.txt
# Hex fields: alu_op br_kind fwd_a fwd_b fwd_st link pred op_a op_b store pc_plus target
# mem_fwd wb_fwd memwb_ctrl, then expected result_o store_data_o mispredict_o correct_pc_o
5 0 0 0 0 0 0 80000001 0 5555 1004 2000 111 222 001 80000001 5555 0 1004
5 0 0 0 0 0 0 3 1f 5555 1004 2000 111 222 002 80000000 5555 0 1004
6 0 0 0 0 0 0 80000000 3f 5555 1004 2000 111 222 004 1 5555 0 1004
7 0 0 0 0 0 0 80000000 4 5555 1004 2000 111 222 008 f8000000 5555 0 1004
8 0 0 0 0 0 0 80000000 7fffffff 5555 1004 2000 111 222 020 1 5555 0 1004
9 0 0 0 0 0 0 80000000 7fffffff 5555 1004 2000 111 222 040 0 5555 0 1004
8 0 0 0 0 0 0 7fffffff 80000000 5555 1004 2000 111 222 080 0 5555 0 1004
a 0 0 0 0 0 0 aaaa bbbb 5555 1004 2000 111 222 200 bbbb 5555 0 1004
a 0 0 1 1 0 0 aaaa bbbb 5555 1004 2000 111 222 400 111 111 0 1004
a 0 0 2 2 0 0 aaaa bbbb 5555 1004 2000 111 222 800 222 222 0 1004
a 0 0 3 3 0 0 aaaa bbbb 5555 1004 2000 111 222 fff 111 111 0 1004
0 0 1 0 0 0 0 aaaa 0 5555 1004 2000 111 222 000 111 5555 0 1004
0 0 2 0 0 0 0 aaaa 0 5555 1004 2000 111 222 a5a 222 5555 0 1004
0 0 3 0 0 0 0 aaaa 0 5555 1004 2000 111 222 5a5 111 5555 0 1004
1 1 0 0 0 0 0 5 5 5555 1004 2000 111 222 123 0 5555 1 2000
1 1 0 0 0 0 1 5 6 5555 1004 2000 111 222 345 ffffffff 5555 1 1004
1 2 0 0 0 0 0 5 6 5555 1004 2000 111 222 456 ffffffff 5555 1 2000
1 3 0 0 0 0 1 ffffffff 1 5555 1004 2000 111 222 567 fffffffe 5555 0 2000
1 4 0 0 0 0 1 ffffffff 1 5555 1004 2000 111 222 678 fffffffe 5555 1 1004
1 5 0 0 0 0 0 ffffffff 1 5555 1004 2000 111 222 789 fffffffe 5555 0 1004
1 6 0 0 0 0 0 ffffffff 1 5555 1004 2000 111 222 89a fffffffe 5555 1 2000
0 0 0 0 0 0 1 1 2 5555 1004 2000 111 222 9ab 3 5555 1 1004
0 7 0 0 0 1 1 1 2 5555 1004 2000 111 222 abc 1004 5555 0 2000
0 8 0 0 0 1 1 3001 10 5555 1004 2000 111 222 cde 1004 5555 1 3010
0 8 0 0 0 1 0 4000 5 5555 c00c 2000 111 222 def c00c 5555 1 4004

//--- bench/execute_stage_checker.sv
`default_nettype none

module execute_stage_checker (
    input logic                              clk,
    input logic                              reset,
    input logic [exec_pkg::XLEN-1:0]         result_o,
    input logic [exec_pkg::XLEN-1:0]         store_data_o,
    input logic [exec_pkg::MEMWB_CTRL_W-1:0] memwb_ctrl_i,
    input logic [exec_pkg::MEMWB_CTRL_W-1:0] memwb_ctrl_o,
    input logic                              mispredict_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // Assertion failures so far

    // EX/MEM register stays cleared while reset is low
    reset_clears: assert property (@(posedge clk)
        !reset |-> (result_o == '0 && store_data_o == '0 && memwb_ctrl_o == '0))
        else begin
            $error("registered outputs are not zero during reset");
            fail_count++;
        end

    ctrl_delay: assert property (@(posedge clk) disable iff (!reset)
        $past(reset) |-> memwb_ctrl_o == $past(memwb_ctrl_i))  // One cycle through the register
        else begin
            $error("memwb_ctrl_o does not match memwb_ctrl_i of the previous cycle");
            fail_count++;
        end

    mispredict_known: assert property (@(posedge clk) disable iff (!reset)
        !$isunknown(mispredict_o))
        else begin
            $error("mispredict_o is unknown");
            fail_count++;
        end

endmodule

bind execute_stage execute_stage_checker u_checker (
    .clk          (clk),
    .reset        (reset),
    .result_o     (result_o),
    .store_data_o (store_data_o),
    .memwb_ctrl_i (memwb_ctrl_i),
    .memwb_ctrl_o (memwb_ctrl_o),
    .mispredict_o (mispredict_o)
);

`default_nettype wire

//--- bench/execute_stage_tb.sv
`default_nettype none

module execute_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import exec_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_RANDOM = 80;

    // One test with its inputs and expected outputs
    typedef struct {
        logic [3:0]              op;
        logic [3:0]              br;
        logic [1:0]              fa, fb, fs;
        logic                    lk, pr;
        logic [XLEN-1:0]         a, b, st, pc, tgt, mem, wb;
        logic [MEMWB_CTRL_W-1:0] ctrl;
        logic [XLEN-1:0]         res, est, cpc;
        logic                    mis;
    } case_t;

    logic                    clk, reset, link_i, predicted_taken_i;
    logic [XLEN-1:0]         op_a_i, op_b_i, store_data_i, pc_plus_i, branch_target_i;
    logic [XLEN-1:0]         mem_fwd_i, wb_fwd_i;
    fwd_sel_t                fwd_a_sel_i, fwd_b_sel_i, fwd_st_sel_i;
    alu_op_t                 alu_op_i;
    br_kind_t                br_kind_i;
    logic [MEMWB_CTRL_W-1:0] memwb_ctrl_i, memwb_ctrl_o;
    logic [XLEN-1:0]         result_o, store_data_o, correct_pc_o;
    logic                    mispredict_o;

    case_t       cases[$];
    int          n_rows, errors, tests_run, tests_failed;
    logic        rows_loaded, case_bad;
    logic [31:0] rng;

    execute_stage UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [XLEN-1:0] fwd_model(input logic [1:0] sel,
                                                 input logic [XLEN-1:0] dec, mem, wb);
        if (sel == 2'd0) return dec;
        if (sel == 2'd2) return wb;
        return mem;  // Codes 1 and 3
    endfunction

    function automatic logic [XLEN-1:0] alu_model(input logic [3:0] op,
                                                 input logic [XLEN-1:0] a, b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SRA:     return $signed(a) >>> b[4:0];
            SLT:     return XLEN'($signed(a) < $signed(b));
            SLTU:    return XLEN'(a < b);
            PASS_B:  return b;
            default: return '0;
        endcase
    endfunction

    function automatic logic taken_model(input logic [3:0] br, input logic [XLEN-1:0] a, b);
        case (br)
            BEQ:                return a == b;
            BNE:                return a != b;
            BLT:                return $signed(a) < $signed(b);
            BGE:                return !($signed(a) < $signed(b));
            BLTU:               return a < b;
            BGEU:               return !(a < b);
            JUMP_REL, JUMP_REG: return 1'b1;
            default:            return 1'b0;
        endcase
    endfunction

    function automatic case_t add_expected(input case_t c);
        logic [XLEN-1:0] a, b, sum;
        logic            taken;
        a = fwd_model(c.fa, c.a, c.mem, c.wb);
        b = fwd_model(c.fb, c.b, c.mem, c.wb);
        sum = alu_model(c.op, a, b);
        taken = taken_model(c.br, a, b);
        c.res = c.lk ? c.pc : sum;
        c.est = fwd_model(c.fs, c.st, c.mem, c.wb);
        c.mis = (taken ^ c.pr) | (c.br == JUMP_REG);  // Register target is never predicted
        c.cpc = (c.br == JUMP_REG) ? {sum[XLEN-1:1], 1'b0} : (taken ? c.tgt : c.pc);
        return c;
    endfunction

    task automatic make_random(output case_t c);
        rng = lcg_step(rng);
        c.op = 4'(rng[31:16] % 16'd11);
        c.br = 4'(rng[15:8] % 8'd9);
        rng = lcg_step(rng);
        {c.fa, c.fb, c.fs, c.lk, c.pr, c.ctrl} = rng[31:12];
        rng = lcg_step(rng);
        c.a = rng;
        rng = lcg_step(rng);
        c.b = (c.ctrl[1:0] == 2'd0) ? c.a : rng;  // Equal operands now and then
        rng = lcg_step(rng);
        c.st = rng;
        rng = lcg_step(rng);
        c.pc = rng;
        rng = lcg_step(rng);
        c.tgt = rng;
        rng = lcg_step(rng);
        c.mem = rng;
        rng = lcg_step(rng);
        c.wb = rng;
        c = add_expected(c);
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got, exp);
        assert (got === exp) else begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            errors++;
            case_bad = 1'b1;
        end
    endtask

    task automatic check_registered(input case_t c);
        check_word("result_o", result_o, c.res);
        check_word("store_data_o", store_data_o, c.est);
        check_word("memwb_ctrl_o", XLEN'(memwb_ctrl_o), XLEN'(c.ctrl));
    endtask

    task automatic end_case(input string kind);
        tests_run++;
        if (case_bad) tests_failed++;
        $display("test %0d %s: %s", tests_run, kind, case_bad ? "mismatch" : "ok");
        case_bad = 1'b0;
    endtask

    // Starts on a falling edge and returns on the next one
    task automatic run_case(input case_t c, input string kind);
        {op_a_i, op_b_i, store_data_i, pc_plus_i} = {c.a, c.b, c.st, c.pc};
        {branch_target_i, mem_fwd_i, wb_fwd_i} = {c.tgt, c.mem, c.wb};
        fwd_a_sel_i = fwd_sel_t'(c.fa);
        fwd_b_sel_i = fwd_sel_t'(c.fb);
        fwd_st_sel_i = fwd_sel_t'(c.fs);
        alu_op_i = alu_op_t'(c.op);
        br_kind_i = br_kind_t'(c.br);
        {link_i, predicted_taken_i, memwb_ctrl_i} = {c.lk, c.pr, c.ctrl};
        #(CLK_PERIOD / 2 - 1);  // Just before the rising edge
        check_word("mispredict_o", XLEN'(mispredict_o), XLEN'(c.mis));
        check_word("correct_pc_o", correct_pc_o, c.cpc);
        @(posedge clk);
        @(negedge clk);
        check_registered(c);
        end_case(kind);
    endtask

    // Watchdog sized from the number of tests
    initial begin
        wait (rows_loaded === 1'b1);
        #((n_rows + NUM_RANDOM + 10) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        case_t c;
        case_t zero_c;
        string line;
        int    fd;
        {rows_loaded, case_bad, errors, tests_run, tests_failed} = '0;
        rng = 32'hff5b_c6c0;
        reset = 1'b1;
        {op_a_i, op_b_i, store_data_i, pc_plus_i, branch_target_i} = '0;
        {mem_fwd_i, wb_fwd_i, link_i, predicted_taken_i, memwb_ctrl_i} = '0;
        fwd_a_sel_i = DECODE;
        fwd_b_sel_i = DECODE;
        fwd_st_sel_i = DECODE;
        alu_op_i = ADD;
        br_kind_i = NONE;
        zero_c = '{default: '0};
        fd = $fopen("bench/execute_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/execute_cases.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") continue;
                if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            c.op, c.br, c.fa, c.fb, c.fs, c.lk, c.pr, c.a, c.b, c.st,
                            c.pc, c.tgt, c.mem, c.wb, c.ctrl, c.res, c.est, c.mis,
                            c.cpc) == 19) begin
                    cases.push_back(c);
                end else begin
                    $display("Unreadable row in the cases file: %s", line);
                    errors++;
                end
            end
            $fclose(fd);
        end
        n_rows = cases.size();
        rows_loaded = 1'b1;

        #1 reset = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        check_registered(zero_c);
        end_case("reset held");
        @(negedge clk) reset = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_registered(zero_c);  // Inputs are all zero
        end_case("first edge after reset");

        foreach (cases[i]) run_case(cases[i], $sformatf("row %0d", i + 1));
        repeat (NUM_RANDOM) begin
            make_random(c);
            run_case(c, "random");
        end

        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, errors, UUT.u_checker.fail_count);
        if (errors == 0 && UUT.u_checker.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- execute_stage.f
src/exec_pkg.sv
src/exec_bus_if.sv
src/operand_forward.sv
src/alu_shifter.sv
src/branch_resolve.sv
src/ex_mem_reg.sv
src/execute_stage.sv
bench/execute_stage_checker.sv
bench/execute_stage_tb.sv

//--- src/alu_shifter.sv
`default_nettype none

module alu_shifter (
    input  exec_pkg::alu_op_t alu_op_i,
    exec_bus_if.alu           bus
);
    import exec_pkg::*;

    logic [XLEN:0]      diff_ext;  // Top bit is the borrow
    logic [XLEN-1:0]    diff;
    logic               overflow;
    logic               lt_s;
    logic               lt_u;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    result;

    // Comparison path, independent of the selected operation
    assign diff_ext = {1'b0, bus.op_a} - {1'b0, bus.op_b};
    assign diff     = diff_ext[XLEN-1:0];

    // Signed overflow when operand signs differ and result sign flips from A
    assign overflow = (bus.op_a[XLEN-1] ^ bus.op_b[XLEN-1])
                    & (diff[XLEN-1] ^ bus.op_a[XLEN-1]);

    assign lt_s  = diff[XLEN-1] ^ overflow;
    assign lt_u  = diff_ext[XLEN];
    assign shamt = bus.op_b[SHAMT_W-1:0];

    always_comb begin
        case (alu_op_i)
            ADD:     result = bus.op_a + bus.op_b;
            SUB:     result = diff;
            AND:     result = bus.op_a & bus.op_b;
            OR:      result = bus.op_a | bus.op_b;
            XOR:     result = bus.op_a ^ bus.op_b;
            SLL:     result = bus.op_a << shamt;
            SRL:     result = bus.op_a >> shamt;
            SRA:     result = $signed(bus.op_a) >>> shamt;  // Sign fill
            SLT:     result = {{(XLEN-1){1'b0}}, lt_s};
            SLTU:    result = {{(XLEN-1){1'b0}}, lt_u};
            PASS_B:  result = bus.op_b;  // LUI
            default: result = '0;
        endcase
    end

    assign bus.result = result;

    // Flags describe op_a against op_b
    assign bus.zero        = (diff == '0);
    assign bus.lt_signed   = lt_s;
    assign bus.lt_unsigned = lt_u;

endmodule

`default_nettype wire

//--- src/branch_resolve.sv
`default_nettype none

module branch_resolve (
    input  exec_pkg::br_kind_t               br_kind_i,
    input  logic                             predicted_taken_i,
    input  logic [exec_pkg::XLEN-1:0]        pc_plus_i,
    input  logic [exec_pkg::XLEN-1:0]        branch_target_i,
    exec_bus_if.branch                       bus,
    output logic                             mispredict_o,
    output logic [exec_pkg::XLEN-1:0]        correct_pc_o
);
    import exec_pkg::*;

    logic taken;     // Actual outcome
    logic is_jalr;

    always_comb begin
        case (br_kind_i)
            BEQ:      taken = bus.zero;
            BNE:      taken = !bus.zero;
            BLT:      taken = bus.lt_signed;
            BGE:      taken = !bus.lt_signed;
            BLTU:     taken = bus.lt_unsigned;
            BGEU:     taken = !bus.lt_unsigned;
            JUMP_REL: taken = 1'b1;
            JUMP_REG: taken = 1'b1;
            default:  taken = 1'b0;  // NONE
        endcase
    end

    assign is_jalr = (br_kind_i == JUMP_REG);

    // Fetch never knows a register target, so JALR always redirects
    assign mispredict_o = (taken ^ predicted_taken_i) | (is_jalr & taken);

    always_comb begin
        if (is_jalr) begin
            correct_pc_o = {bus.result[XLEN-1:1], 1'b0};
        end else if (taken) begin
            correct_pc_o = branch_target_i;
        end else begin
            correct_pc_o = pc_plus_i;  // Fall through
        end
    end

endmodule

`default_nettype wire

//--- src/ex_mem_reg.sv
`default_nettype none

module ex_mem_reg (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  link_i,
    input  logic [exec_pkg::XLEN-1:0]             pc_plus_i,
    input  logic [exec_pkg::MEMWB_CTRL_W-1:0]     memwb_ctrl_i,
    exec_bus_if.retire                            bus,
    output logic [exec_pkg::XLEN-1:0]             result_o,
    output logic [exec_pkg::XLEN-1:0]             store_data_o,
    output logic [exec_pkg::MEMWB_CTRL_W-1:0]     memwb_ctrl_o
);
    import exec_pkg::*;

    logic [XLEN-1:0] retire_value;

    // JAL and JALR write the return address
    assign retire_value = link_i ? pc_plus_i : bus.result;

    // EX/MEM pipeline register
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            result_o     <= '0;
            store_data_o <= '0;
            memwb_ctrl_o <= '0;  // No memory access, no write-back
        end else begin
            result_o     <= retire_value;
            store_data_o <= bus.store_data;
            memwb_ctrl_o <= memwb_ctrl_i;
        end
    end

endmodule

`default_nettype wire

//--- src/exec_bus_if.sv
`default_nettype none

interface exec_bus_if;
    import exec_pkg::*;

    logic [XLEN-1:0] op_a;        // Forwarded operand A
    logic [XLEN-1:0] op_b;        // Forwarded operand B
    logic [XLEN-1:0] store_data;  // Forwarded store data
    logic [XLEN-1:0] result;      // ALU result
    logic            zero;
    logic            lt_signed;
    logic            lt_unsigned;

    modport operand_forward (output op_a, output op_b, output store_data);

    modport alu (
        input  op_a, input op_b,
        output result, output zero, output lt_signed, output lt_unsigned
    );

    modport branch (input result, input zero, input lt_signed, input lt_unsigned);

    modport retire (input result, input store_data);

endinterface

`default_nettype wire

//--- src/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int XLEN         = 32;
    localparam int ALU_OP_W     = 4;
    localparam int BR_KIND_W    = 4;   // Nine branch kinds, so 3 bits are not enough
    localparam int FWD_SEL_W    = 2;
    localparam int SHAMT_W      = 5;   // Shift amount taken from op_b
    localparam int MEMWB_CTRL_W = 12;  // Memory and write-back control bits

    // ALU operations
    typedef enum logic [ALU_OP_W-1:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,   // Also used for conditional branches
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLL    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        SLT    = 4'd8,
        SLTU   = 4'd9,
        PASS_B = 4'd10   // LUI
    } alu_op_t;

    // Branch kinds
    typedef enum logic [BR_KIND_W-1:0] {
        NONE     = 4'd0,
        BEQ      = 4'd1,
        BNE      = 4'd2,
        BLT      = 4'd3,
        BGE      = 4'd4,
        BLTU     = 4'd5,
        BGEU     = 4'd6,
        JUMP_REL = 4'd7,  // JAL
        JUMP_REG = 4'd8   // JALR
    } br_kind_t;

    // Forwarding select, the last code aliases the memory stage
    typedef enum logic [FWD_SEL_W-1:0] {
        DECODE    = 2'd0,
        FROM_MEM  = 2'd1,
        FROM_WB   = 2'd2,
        FROM_MEM2 = 2'd3
    } fwd_sel_t;

endpackage

`default_nettype wire

//--- src/execute_stage.sv
`default_nettype none

module execute_stage (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [exec_pkg::XLEN-1:0]         op_a_i,
    input  logic [exec_pkg::XLEN-1:0]         op_b_i,
    input  logic [exec_pkg::XLEN-1:0]         store_data_i,
    input  logic [exec_pkg::XLEN-1:0]         pc_plus_i,
    input  logic [exec_pkg::XLEN-1:0]         branch_target_i,
    input  logic [exec_pkg::XLEN-1:0]         mem_fwd_i,
    input  logic [exec_pkg::XLEN-1:0]         wb_fwd_i,
    input  exec_pkg::fwd_sel_t                fwd_a_sel_i,
    input  exec_pkg::fwd_sel_t                fwd_b_sel_i,
    input  exec_pkg::fwd_sel_t                fwd_st_sel_i,
    input  exec_pkg::alu_op_t                 alu_op_i,
    input  exec_pkg::br_kind_t                br_kind_i,
    input  logic                              link_i,
    input  logic                              predicted_taken_i,
    input  logic [exec_pkg::MEMWB_CTRL_W-1:0] memwb_ctrl_i,
    output logic [exec_pkg::XLEN-1:0]         result_o,
    output logic [exec_pkg::XLEN-1:0]         store_data_o,
    output logic [exec_pkg::MEMWB_CTRL_W-1:0] memwb_ctrl_o,
    output logic                              mispredict_o,
    output logic [exec_pkg::XLEN-1:0]         correct_pc_o
);

    exec_bus_if bus ();  // Operands and ALU outputs

    operand_forward u_fwd (
        .fwd_a_sel_i  (fwd_a_sel_i),
        .fwd_b_sel_i  (fwd_b_sel_i),
        .fwd_st_sel_i (fwd_st_sel_i),
        .op_a_i       (op_a_i),
        .op_b_i       (op_b_i),
        .store_data_i (store_data_i),
        .mem_fwd_i    (mem_fwd_i),
        .wb_fwd_i     (wb_fwd_i),
        .bus          (bus.operand_forward)
    );

    alu_shifter u_alu (
        .alu_op_i (alu_op_i),
        .bus      (bus.alu)
    );

    // Same-cycle redirect for fetch
    branch_resolve u_branch (
        .br_kind_i         (br_kind_i),
        .predicted_taken_i (predicted_taken_i),
        .pc_plus_i         (pc_plus_i),
        .branch_target_i   (branch_target_i),
        .bus               (bus.branch),
        .mispredict_o      (mispredict_o),
        .correct_pc_o      (correct_pc_o)
    );

    ex_mem_reg u_ex_mem (
        .clk          (clk),
        .reset        (reset),
        .link_i       (link_i),
        .pc_plus_i    (pc_plus_i),
        .memwb_ctrl_i (memwb_ctrl_i),
        .bus          (bus.retire),
        .result_o     (result_o),
        .store_data_o (store_data_o),
        .memwb_ctrl_o (memwb_ctrl_o)
    );

endmodule

`default_nettype wire

//--- src/operand_forward.sv
`default_nettype none

module operand_forward (
    input  exec_pkg::fwd_sel_t               fwd_a_sel_i,
    input  exec_pkg::fwd_sel_t               fwd_b_sel_i,
    input  exec_pkg::fwd_sel_t               fwd_st_sel_i,
    input  logic [exec_pkg::XLEN-1:0]        op_a_i,
    input  logic [exec_pkg::XLEN-1:0]        op_b_i,
    input  logic [exec_pkg::XLEN-1:0]        store_data_i,
    input  logic [exec_pkg::XLEN-1:0]        mem_fwd_i,
    input  logic [exec_pkg::XLEN-1:0]        wb_fwd_i,
    exec_bus_if.operand_forward              bus
);
    import exec_pkg::*;

    // One selector, used for all three values
    function automatic logic [XLEN-1:0] pick(
        input fwd_sel_t        sel,
        input logic [XLEN-1:0] dec_val,
        input logic [XLEN-1:0] mem_val,
        input logic [XLEN-1:0] wb_val
    );
        logic [XLEN-1:0] val;
        case (sel)
            DECODE:  val = dec_val;
            FROM_WB: val = wb_val;
            default: val = mem_val;  // Younger result wins on both mem codes
        endcase
        return val;
    endfunction

    assign bus.op_a       = pick(fwd_a_sel_i,  op_a_i,       mem_fwd_i, wb_fwd_i);
    assign bus.op_b       = pick(fwd_b_sel_i,  op_b_i,       mem_fwd_i, wb_fwd_i);
    assign bus.store_data = pick(fwd_st_sel_i, store_data_i, mem_fwd_i, wb_fwd_i);

endmodule

`default_nettype wire
